// File: compile.f
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/mulCounter.sv
hdl/coreSequencer.sv
hdl/miniCore.sv
tests/retireChecker.sv
tests/miniCoreTb.sv

// File: hdl/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  ctrlPkg::aluOp_t aluOp,
    input  logic [31:0]     opA,
    input  logic [31:0]     opB,
    input  logic [4:0]      shamt,
    input  logic [31:0]     hiValue,
    input  logic [31:0]     loValue,
    output logic [31:0]     result,
    output logic            equal,
    output logic            moveTaken
);
    import ctrlPkg::*;

    always_comb
    begin
        case (aluOp)
            // No overflow trap, so ADD and ADDU share one path.
            aluAdd:   result = opA + opB;
            aluSub:   result = opA - opB;
            aluAnd:   result = opA & opB;
            aluOr:    result = opA | opB;
            aluXor:   result = opA ^ opB;
            aluNor:   result = ~(opA | opB);
            aluSll:   result = opB << shamt;
            aluSrl:   result = opB >> shamt;
            aluSra:   result = $signed(opB) >>> shamt;
            aluSllv:  result = opB << opA[4:0];
            aluSrlv:  result = opB >> opA[4:0];
            aluSrav:  result = $signed(opB) >>> opA[4:0];
            aluSlt:   result = {31'd0, $signed(opA) < $signed(opB)};
            aluSltu:  result = {31'd0, opA < opB};
            aluPassB: result = opB;
            aluMove:  result = opA;
            aluMfhi:  result = hiValue;
            aluMflo:  result = loValue;
            default:  result = 32'd0;
        endcase
    end

    assign equal = opA == opB;

    // MOVN condition, rt nonzero.
    assign moveTaken = |opB;

endmodule

`default_nettype wire

// File: hdl/coreSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module coreSequencer #(
    parameter logic [31:0] resetVector = 32'h0
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [31:0]          instrData,
    input  ctrlPkg::ctrl_t       ctrl,
    input  logic [31:0]          rsValue,
    input  logic [31:0]          rtValue,
    input  logic [31:0]          aluResult,
    input  logic                 aluZeroCmp,
    input  logic                 moveTaken,
    input  logic                 mulDone,
    input  logic [31:0]          loValue,
    output isaPkg::instrFields_t instr,
    output logic [31:0]          instrAddr,
    output logic                 mulStart,
    output logic                 wrEn,
    output logic [4:0]           wrReg,
    output logic [31:0]          wrData,
    output logic                 retireValid,
    output ctrlPkg::retire_t     retireInfo
);
    import isaPkg::*;
    import ctrlPkg::*;

    seqState_t   state;
    logic [31:0] pc;
    logic [31:0] pcPlus4;
    logic [31:0] nextPc;
    logic [31:0] resultReg;
    logic [15:0] imm;
    logic        takenReg;
    logic        doWrite;
    logic        isMultiply;

    assign isMultiply = ctrl.mulOp inside {mulMult, mulMultu, mulMul};
    assign mulStart   = state == execute && (isMultiply || ctrl.mulOp inside {mulMthi, mulMtlo});
    assign instrAddr  = pc;
    assign pcPlus4    = pc + 32'd4;
    assign imm        = imm16(instr);

    always_comb
    begin
        if (ctrl.jump)
            nextPc = {pcPlus4[31:28], target26(instr), 2'b00};
        else if (takenReg)
            nextPc = pcPlus4 + {{14{imm[15]}}, imm, 2'b00};
        else
            nextPc = pcPlus4;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            state <= fetch;
            pc    <= resetVector;
        end
        else
        begin
            case (state)
                fetch:     state <= execute;
                execute:   state <= isMultiply ? mulWait : writeback;
                mulWait:   if (mulDone) state <= writeback;
                writeback:
                begin
                    pc    <= nextPc;
                    state <= fetch;
                end
                default:   state <= fetch;
            endcase
        end
    end

    // Instruction and execute results, held until writeback.
    always_ff @(posedge clk)
    begin
        if (state == fetch)
            instr <= instrFields_t'(instrData);
        if (state == execute)
        begin
            resultReg <= aluResult;
            takenReg  <= (ctrl.branchEq && aluZeroCmp) || (ctrl.branchNe && !aluZeroCmp);
            // MOVZ inverts the rt-nonzero test.
            doWrite   <= ctrl.regWrite && (!ctrl.condMove || (moveTaken ^ ctrl.moveIfZero));
        end
    end

    always_comb
    begin
        case (ctrl.dstSel)
            dstRt:   wrReg = instr.rt;
            dstRd:   wrReg = instr.rd;
            default: wrReg = 5'd0;
        endcase
    end

    assign wrData      = ctrl.mulOp == mulMul ? loValue : resultReg;
    assign wrEn        = state == writeback && doWrite;
    assign retireValid = state == writeback;
    assign retireInfo  = '{pc: pc, writeEn: doWrite, writeReg: wrReg, writeData: wrData};

    // A multiply start clears done for the wait that follows.
    assert property (@(posedge clk) disable iff (!rstN)
        mulStart && isMultiply |=> !mulDone);

    // Branches compare rs with rt, never with an immediate.
    assert property (@(posedge clk) disable iff (!rstN)
        state == execute && (ctrl.branchEq || ctrl.branchNe)
            |-> aluZeroCmp == (rsValue == rtValue));

endmodule

`default_nettype wire

// File: hdl/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    typedef enum logic [4:0] {
        aluNone, aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
        aluSll, aluSrl, aluSra, aluSllv, aluSrlv, aluSrav,
        aluSlt, aluSltu, aluPassB, aluMove, aluMfhi, aluMflo
    } aluOp_t;

    typedef enum logic [1:0] {dstNone, dstRt, dstRd} dstSel_t;

    typedef enum logic [2:0] {
        mulNone, mulMult, mulMultu, mulMul, mulMthi, mulMtlo, mulMfhi, mulMflo
    } mulOp_t;

    typedef struct packed {
        aluOp_t  aluOp;
        logic    aluSrcImm;
        logic    immZeroExt;
        logic    immUpper;
        dstSel_t dstSel;
        logic    regWrite;
        logic    branchEq;
        logic    branchNe;
        logic    jump;
        mulOp_t  mulOp;
        logic    condMove;
        logic    moveIfZero;
    } ctrl_t;

    typedef enum logic [1:0] {fetch, execute, mulWait, writeback} seqState_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        writeEn;
        logic [4:0]  writeReg;
        logic [31:0] writeData;
    } retire_t;

endpackage

`default_nettype wire

// File: hdl/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  isaPkg::instrFields_t instr,
    output ctrlPkg::ctrl_t       ctrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    function automatic aluOp_t rTypeOp(input logic [5:0] funct);
        case (funct)
            fnAdd, fnAddu: return aluAdd;
            fnSub, fnSubu: return aluSub;
            fnAnd:         return aluAnd;
            fnOr:          return aluOr;
            fnXor:         return aluXor;
            fnNor:         return aluNor;
            fnSll:         return aluSll;
            fnSrl:         return aluSrl;
            fnSra:         return aluSra;
            fnSllv:        return aluSllv;
            fnSrlv:        return aluSrlv;
            fnSrav:        return aluSrav;
            fnSlt:         return aluSlt;
            fnSltu:        return aluSltu;
            fnMfhi:        return aluMfhi;
            fnMflo:        return aluMflo;
            default:       return aluMove;
        endcase
    endfunction

    always_comb
    begin
        ctrl = '0;

        case (instr.opcode)
            opSpecial:
                case (instr.funct)
                    fnAdd, fnAddu, fnSub , fnSubu,
                    fnSll, fnSllv, fnSra , fnSrav,
                    fnSrl, fnSrlv, fnAnd , fnNor ,
                    fnOr , fnXor , fnMovn, fnMovz,
                    fnSlt, fnSltu, fnMfhi, fnMflo:
                    begin
                        ctrl.aluOp      = rTypeOp(instr.funct);
                        ctrl.dstSel     = dstRd;
                        ctrl.regWrite   = 1'b1;
                        ctrl.condMove   = instr.funct inside {fnMovn, fnMovz};
                        ctrl.moveIfZero = instr.funct == fnMovz;
                        if (instr.funct == fnMfhi)
                            ctrl.mulOp = mulMfhi;
                        else if (instr.funct == fnMflo)
                            ctrl.mulOp = mulMflo;
                    end

                    fnMult:  ctrl.mulOp = mulMult;
                    fnMultu: ctrl.mulOp = mulMultu;
                    fnMthi:  ctrl.mulOp = mulMthi;
                    fnMtlo:  ctrl.mulOp = mulMtlo;

                    default:;
                endcase

            opSpecial2:
                if (instr.funct == fnMul)
                begin
                    ctrl.mulOp    = mulMul;
                    ctrl.dstSel   = dstRd;
                    ctrl.regWrite = 1'b1;
                end

            opAddi, opAddiu, opSlti, opSltiu:
            begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.dstSel    = dstRt;
                ctrl.regWrite  = 1'b1;
                case (instr.opcode)
                    opSlti:  ctrl.aluOp = aluSlt;
                    // SLTIU still sign-extends, then compares unsigned.
                    opSltiu: ctrl.aluOp = aluSltu;
                    default: ctrl.aluOp = aluAdd;
                endcase
            end

            opAndi, opOri, opXori:
            begin
                ctrl.aluSrcImm  = 1'b1;
                ctrl.immZeroExt = 1'b1;
                ctrl.dstSel     = dstRt;
                ctrl.regWrite   = 1'b1;
                case (instr.opcode)
                    opAndi:  ctrl.aluOp = aluAnd;
                    opOri:   ctrl.aluOp = aluOr;
                    default: ctrl.aluOp = aluXor;
                endcase
            end

            opLui:
            begin
                ctrl.aluOp     = aluPassB;
                ctrl.aluSrcImm = 1'b1;
                ctrl.immUpper  = 1'b1;
                ctrl.dstSel    = dstRt;
                ctrl.regWrite  = 1'b1;
            end

            opBeq: ctrl.branchEq = 1'b1;
            opBne: ctrl.branchNe = 1'b1;
            opJ:   ctrl.jump     = 1'b1;

            default:;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/isaPkg.sv
`default_nettype none

package isaPkg;

    localparam logic [5:0] opSpecial  = 6'h00;
    localparam logic [5:0] opSpecial2 = 6'h1c;
    localparam logic [5:0] opJ        = 6'h02;
    localparam logic [5:0] opBeq      = 6'h04;
    localparam logic [5:0] opBne      = 6'h05;
    localparam logic [5:0] opAddi     = 6'h08;
    localparam logic [5:0] opAddiu    = 6'h09;
    localparam logic [5:0] opSlti     = 6'h0a;
    localparam logic [5:0] opSltiu    = 6'h0b;
    localparam logic [5:0] opAndi     = 6'h0c;
    localparam logic [5:0] opOri      = 6'h0d;
    localparam logic [5:0] opXori     = 6'h0e;
    localparam logic [5:0] opLui      = 6'h0f;

    localparam logic [5:0] fnSll   = 6'h00;
    localparam logic [5:0] fnSrl   = 6'h02;
    localparam logic [5:0] fnSra   = 6'h03;
    localparam logic [5:0] fnSllv  = 6'h04;
    localparam logic [5:0] fnSrlv  = 6'h06;
    localparam logic [5:0] fnSrav  = 6'h07;
    localparam logic [5:0] fnMovz  = 6'h0a;
    localparam logic [5:0] fnMovn  = 6'h0b;
    localparam logic [5:0] fnMfhi  = 6'h10;
    localparam logic [5:0] fnMthi  = 6'h11;
    localparam logic [5:0] fnMflo  = 6'h12;
    localparam logic [5:0] fnMtlo  = 6'h13;
    localparam logic [5:0] fnMult  = 6'h18;
    localparam logic [5:0] fnMultu = 6'h19;
    localparam logic [5:0] fnAdd   = 6'h20;
    localparam logic [5:0] fnAddu  = 6'h21;
    localparam logic [5:0] fnSub   = 6'h22;
    localparam logic [5:0] fnSubu  = 6'h23;
    localparam logic [5:0] fnAnd   = 6'h24;
    localparam logic [5:0] fnOr    = 6'h25;
    localparam logic [5:0] fnXor   = 6'h26;
    localparam logic [5:0] fnNor   = 6'h27;
    localparam logic [5:0] fnSlt   = 6'h2a;
    localparam logic [5:0] fnSltu  = 6'h2b;

    // Special-2 function code.
    localparam logic [5:0] fnMul   = 6'h02;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instrFields_t;

    // The I-type and J-type fields overlay the low bits of the R-type layout.
    function automatic logic [15:0] imm16(input instrFields_t i);
        return {i.rd, i.shamt, i.funct};
    endfunction

    function automatic logic [25:0] target26(input instrFields_t i);
        return {i.rs, i.rt, i.rd, i.shamt, i.funct};
    endfunction

endpackage

`default_nettype wire

// File: hdl/miniCore.sv
`timescale 1ns/1ps
`default_nettype none

module miniCore #(
    parameter logic [31:0] resetVector = 32'h0,
    parameter int          mulSteps    = 32
) (
    input  logic             clk,
    input  logic             rstN,
    output logic [31:0]      instrAddr,
    input  logic [31:0]      instrData,
    output logic             retireValid,
    output ctrlPkg::retire_t retireInfo
);
    import isaPkg::*;
    import ctrlPkg::*;

    instrFields_t instr;
    ctrl_t        ctrl;
    logic [31:0]  rsValue;
    logic [31:0]  rtValue;
    logic [15:0]  imm;
    logic [31:0]  immValue;
    logic [31:0]  aluOpB;
    logic [31:0]  aluResult;
    logic         equal;
    logic         moveTaken;
    logic         mulStart;
    logic         mulDone;
    logic [31:0]  hiValue;
    logic [31:0]  loValue;
    logic         wrEn;
    logic [4:0]   wrReg;
    logic [31:0]  wrData;

    // Immediate operand for the I-type forms.
    assign imm      = imm16(instr);
    assign immValue = ctrl.immUpper   ? {imm, 16'd0} :
                      ctrl.immZeroExt ? {16'd0, imm} :
                                        {{16{imm[15]}}, imm};
    assign aluOpB   = ctrl.aluSrcImm ? immValue : rtValue;

    coreSequencer #(.resetVector(resetVector)) i_coreSequencer (
        .clk(clk), .rstN(rstN), .instrData(instrData), .ctrl(ctrl),
        .rsValue(rsValue), .rtValue(rtValue), .aluResult(aluResult),
        .aluZeroCmp(equal), .moveTaken(moveTaken), .mulDone(mulDone),
        .loValue(loValue), .instr(instr), .instrAddr(instrAddr),
        .mulStart(mulStart), .wrEn(wrEn), .wrReg(wrReg), .wrData(wrData),
        .retireValid(retireValid), .retireInfo(retireInfo)
    );

    instrDecoder i_instrDecoder (.instr(instr), .ctrl(ctrl));

    regFile i_regFile (
        .clk(clk), .rstN(rstN), .rdAddrA(instr.rs), .rdAddrB(instr.rt),
        .rdDataA(rsValue), .rdDataB(rtValue),
        .wrEn(wrEn), .wrAddr(wrReg), .wrData(wrData)
    );

    aluUnit i_aluUnit (
        .aluOp(ctrl.aluOp), .opA(rsValue), .opB(aluOpB), .shamt(instr.shamt),
        .hiValue(hiValue), .loValue(loValue),
        .result(aluResult), .equal(equal), .moveTaken(moveTaken)
    );

    mulCounter #(.mulSteps(mulSteps)) i_mulCounter (
        .clk(clk), .rstN(rstN), .mulStart(mulStart), .mulOp(ctrl.mulOp),
        .opA(rsValue), .opB(rtValue), .mulDone(mulDone),
        .hiValue(hiValue), .loValue(loValue)
    );

endmodule

`default_nettype wire

// File: hdl/mulCounter.sv
`timescale 1ns/1ps
`default_nettype none

module mulCounter #(
    parameter int mulSteps = 32
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            mulStart,
    input  ctrlPkg::mulOp_t mulOp,
    input  logic [31:0]     opA,
    input  logic [31:0]     opB,
    output logic            mulDone,
    output logic [31:0]     hiValue,
    output logic [31:0]     loValue
);
    import ctrlPkg::*;

    localparam int cntW = $clog2(mulSteps + 1);

    logic [cntW-1:0] count;
    logic            busy;
    logic            lastStep;
    logic            isMultiply;
    logic            signedOp;
    logic            negResult;
    logic            loOnly;
    logic [31:0]     magA;
    logic [31:0]     magB;
    logic [31:0]     mcand;
    logic [63:0]     prod;
    logic [63:0]     stepProd;
    logic [63:0]     finalProd;

    // One shift-add step on {upper accumulator, remaining multiplier bits}.
    function automatic logic [63:0] mulStep(input logic [63:0] p, input logic [31:0] m);
        logic [32:0] upper;
        upper = {1'b0, p[63:32]} + (p[0] ? {1'b0, m} : 33'd0);
        return {upper, p[31:1]};
    endfunction

    assign isMultiply = mulOp inside {mulMult, mulMultu, mulMul};
    assign signedOp   = mulOp inside {mulMult, mulMul};
    assign magA       = (signedOp && opA[31]) ? -opA : opA;
    assign magB       = (signedOp && opB[31]) ? -opB : opB;
    assign stepProd   = mulStep(prod, mcand);
    assign finalProd  = negResult ? -stepProd : stepProd;
    assign lastStep   = busy && count == cntW'(mulSteps - 1);

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            busy    <= 1'b0;
            mulDone <= 1'b0;
            count   <= '0;
            hiValue <= '0;
            loValue <= '0;
        end
        else if (mulStart)
        begin
            // The first step happens on the start edge.
            busy    <= isMultiply;
            mulDone <= !isMultiply;
            count   <= cntW'(1);
            if (mulOp == mulMthi)
                hiValue <= opA;
            if (mulOp == mulMtlo)
                loValue <= opA;
        end
        else if (lastStep)
        begin
            busy    <= 1'b0;
            mulDone <= 1'b1;
            count   <= cntW'(mulSteps);
            loValue <= finalProd[31:0];
            if (!loOnly)
                hiValue <= finalProd[63:32];
        end
        else if (busy)
            count <= count + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (mulStart)
        begin
            prod      <= mulStep({32'd0, magB}, magA);
            mcand     <= magA;
            negResult <= signedOp && (opA[31] ^ opB[31]);
            loOnly    <= mulOp == mulMul;
        end
        else if (busy)
            prod <= stepProd;
    end

    assert property (@(posedge clk) disable iff (!rstN) count <= cntW'(mulSteps));

endmodule

`default_nettype wire

// File: hdl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rdAddrA,
    input  logic [4:0]  rdAddrB,
    output logic [31:0] rdDataA,
    output logic [31:0] rdDataB,
    input  logic        wrEn,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData
);
    logic [31:0] regs [32];

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wrEn && wrAddr != 5'd0)
            regs[wrAddr] <= wrData;
    end

    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

    assert property (@(posedge clk) disable iff (!rstN)
        (rdAddrA == 5'd0 |-> rdDataA == '0) and (rdAddrB == 5'd0 |-> rdDataB == '0));

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the miniCore testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module miniCoreTb -o miniCoreSim

./obj_dir/miniCoreSim | tee sim.log

if grep -qx "Done: no errors" sim.log
then
    exit 0
fi
echo "Simulation failed, see sim.log"
exit 1

// File: tests/miniCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module miniCoreTb;
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int retireTarget = 400;
    localparam int cycleLimit   = 20000;

    localparam logic [5:0] rFuncts [18] = '{
        fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu,
        fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav, fnMovn, fnMovz
    };
    localparam logic [5:0] iOps [8] = '{
        opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui
    };
    localparam logic [5:0] hiLoFuncts [6] = '{fnMult, fnMultu, fnMthi, fnMtlo, fnMfhi, fnMflo};

    logic        clk;
    logic        rstN;
    logic [31:0] instrAddr;
    logic [31:0] instrData = '0;
    logic        retireValid;
    retire_t     retireInfo;
    logic [31:0] rom [64];
    int          seed;
    int          errCount;
    int          retireCount;
    int          cycles;

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Loads, BREAK, CLZ and JAL are outside the core's ISA.
    function automatic logic [31:0] unsupportedWord(input logic [31:0] r);
        case (r[1:0])
            2'd0:    return {6'h23, r[25:0]};
            2'd1:    return {opSpecial, r[25:6], 6'h0d};
            2'd2:    return {opSpecial2, r[25:6], 6'h20};
            default: return {6'h03, r[25:0]};
        endcase
    endfunction

    // Registers 0 to 7 only, so operands repeat and r0 is a frequent target.
    task automatic buildProgram();
        logic [31:0] word;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        for (int i = 0; i < 64; i++)
        begin
            word = $random(seed);
            rs   = 5'(randBelow(8));
            rt   = 5'(randBelow(8));
            rd   = 5'(randBelow(8));
            case (randBelow(16))
                0, 1, 2, 3, 4: rom[i] = {opSpecial, rs, rt, rd, word[10:6], rFuncts[randBelow(18)]};
                5, 6, 7, 8:    rom[i] = {iOps[randBelow(8)], rs, rt, word[15:0]};
                9, 10:         rom[i] = {opSpecial, rs, rt, rd, 5'd0, hiLoFuncts[randBelow(6)]};
                11:            rom[i] = {opSpecial2, rs, rt, rd, 5'd0, fnMul};
                // Forward offsets only.
                12, 13:        rom[i] = {word[31] ? opBne : opBeq, rs, rt, 16'(randBelow(6))};
                14:            rom[i] = {opJ, word[25:0]};
                default:       rom[i] = unsupportedWord(word);
            endcase
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk)
        instrData <= rom[instrAddr[7:2]];

    miniCore #(.resetVector(32'h0), .mulSteps(32)) i_miniCore (
        .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instrData(instrData),
        .retireValid(retireValid), .retireInfo(retireInfo)
    );

    retireChecker #(.resetVector(32'h0), .retireWindow(40)) i_retireChecker (
        .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instrData(instrData),
        .retireValid(retireValid), .retireInfo(retireInfo),
        .errCount(errCount), .retireCount(retireCount)
    );

    initial
    begin
        seed = 32'h4dde;
        rstN = 1'b0;
        buildProgram();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN   = 1'b1;
        cycles = 0;
        while (retireCount < retireTarget && cycles < cycleLimit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (retireCount < retireTarget)
            $display("Timeout: only %0d of %0d instructions retired in %0d cycles",
                     retireCount, retireTarget, cycles);
        $display("Summary: %0d instructions retired, %0d errors", retireCount, errCount);
        if (errCount == 0 && retireCount >= retireTarget)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/retireChecker.sv
`timescale 1ns/1ps
`default_nettype none

module retireChecker #(
    parameter logic [31:0] resetVector  = 32'h0,
    parameter int          retireWindow = 40
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic [31:0]      instrAddr,
    input  logic [31:0]      instrData,
    input  logic             retireValid,
    input  ctrlPkg::retire_t retireInfo,
    output int               errCount,
    output int               retireCount
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic [31:0] regs [32];
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] pc;
    int          idleCycles;

    // One instruction of the ISA on the model state.
    function automatic retire_t refInstr(
        input  logic [31:0] word,
        input  logic [31:0] curPc,
        input  logic [31:0] a,
        input  logic [31:0] b,
        input  logic [31:0] hiIn,
        input  logic [31:0] loIn,
        output logic [31:0] hiOut,
        output logic [31:0] loOut,
        output logic [31:0] nextPc
    );
        retire_t     r;
        logic [31:0] pc4;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [63:0] prod;
        logic [4:0]  sh;
        pc4    = curPc + 32'd4;
        sext   = {{16{word[15]}}, word[15:0]};
        zext   = {16'd0, word[15:0]};
        sh     = word[10:6];
        r      = '{pc: curPc, writeEn: 1'b0, writeReg: word[15:11], writeData: 32'd0};
        hiOut  = hiIn;
        loOut  = loIn;
        nextPc = pc4;
        case (word[31:26])
            opSpecial:
            begin
                r.writeEn = !(word[5:0] inside {fnMult, fnMultu, fnMthi, fnMtlo});
                case (word[5:0])
                    fnAdd, fnAddu: r.writeData = a + b;
                    fnSub, fnSubu: r.writeData = a - b;
                    fnAnd:   r.writeData = a & b;
                    fnOr:    r.writeData = a | b;
                    fnXor:   r.writeData = a ^ b;
                    fnNor:   r.writeData = ~(a | b);
                    fnSll:   r.writeData = b << sh;
                    fnSrl:   r.writeData = b >> sh;
                    fnSra:   r.writeData = $signed(b) >>> sh;
                    fnSllv:  r.writeData = b << a[4:0];
                    fnSrlv:  r.writeData = b >> a[4:0];
                    fnSrav:  r.writeData = $signed(b) >>> a[4:0];
                    fnSlt:   r.writeData = {31'd0, $signed(a) < $signed(b)};
                    fnSltu:  r.writeData = {31'd0, a < b};
                    fnMfhi:  r.writeData = hiIn;
                    fnMflo:  r.writeData = loIn;
                    fnMthi:  hiOut = a;
                    fnMtlo:  loOut = a;
                    fnMult:  {hiOut, loOut} = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                    fnMultu: {hiOut, loOut} = {32'd0, a} * {32'd0, b};
                    fnMovn, fnMovz:
                    begin
                        r.writeData = a;
                        r.writeEn   = (word[5:0] == fnMovn) ? b != 32'd0 : b == 32'd0;
                    end
                    default: r.writeEn = 1'b0;
                endcase
            end
            opSpecial2:
                if (word[5:0] == fnMul)
                begin
                    prod        = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                    loOut       = prod[31:0];
                    r.writeEn   = 1'b1;
                    r.writeData = prod[31:0];
                end
            opAddi, opAddiu: r.writeData = a + sext;
            opSlti:  r.writeData = {31'd0, $signed(a) < $signed(sext)};
            opSltiu: r.writeData = {31'd0, a < sext};
            opAndi:  r.writeData = a & zext;
            opOri:   r.writeData = a | zext;
            opXori:  r.writeData = a ^ zext;
            opLui:   r.writeData = {word[15:0], 16'd0};
            opBeq:   nextPc = (a == b) ? pc4 + {sext[29:0], 2'b00} : pc4;
            opBne:   nextPc = (a != b) ? pc4 + {sext[29:0], 2'b00} : pc4;
            opJ:     nextPc = {pc4[31:28], word[25:0], 2'b00};
            default:;
        endcase
        // I-type ALU opcodes span 0x08 to 0x0f and write rt.
        if (word[31:29] == 3'b001)
        begin
            r.writeEn  = 1'b1;
            r.writeReg = word[20:16];
        end
        return r;
    endfunction

    task automatic flagMismatch(input string field, input logic [31:0] expVal,
                                input logic [31:0] gotVal);
        $display("ERR %0t: %s at pc %h, expected %h, got %h", $time, field, pc, expVal, gotVal);
        errCount++;
    endtask

    always @(posedge clk)
    begin : compare
        retire_t     expected;
        logic [31:0] newHi;
        logic [31:0] newLo;
        logic [31:0] nextPc;
        if (!rstN)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] = '0;
            hi          = '0;
            lo          = '0;
            pc          = resetVector;
            idleCycles  = 0;
            errCount    = 0;
            retireCount = 0;
        end
        else if (retireValid)
        begin
            expected = refInstr(instrData, pc, regs[instrData[25:21]], regs[instrData[20:16]],
                                hi, lo, newHi, newLo, nextPc);
            if (instrAddr !== pc)
                flagMismatch("instrAddr", pc, instrAddr);
            if (retireInfo.pc !== expected.pc)
                flagMismatch("pc", expected.pc, retireInfo.pc);
            if (retireInfo.writeEn !== expected.writeEn)
                flagMismatch("writeEn", 32'(expected.writeEn), 32'(retireInfo.writeEn));
            if (expected.writeEn && retireInfo.writeReg !== expected.writeReg)
                flagMismatch("writeReg", 32'(expected.writeReg), 32'(retireInfo.writeReg));
            if (expected.writeEn && retireInfo.writeData !== expected.writeData)
                flagMismatch("writeData", expected.writeData, retireInfo.writeData);
            // Register 0 stays zero.
            if (expected.writeEn && expected.writeReg != 5'd0)
                regs[expected.writeReg] = expected.writeData;
            hi         = newHi;
            lo         = newLo;
            pc         = nextPc;
            idleCycles = 0;
            retireCount++;
        end
        else
        begin
            idleCycles++;
            if (idleCycles >= retireWindow)
            begin
                $display("No retirement within %0d cycles of the fetch at address %h",
                         retireWindow, instrAddr);
                errCount++;
                idleCycles = 0;
            end
        end
    end

endmodule

`default_nettype wire
